// ==== Bender.yml ====
package:
  name: axil_mem

export_include_dirs:
  - hdl

sources:
  - files:
      - hdl/axil_mem_pkg.sv
      - hdl/axil_mem_decode.sv
      - hdl/axil_mem_execute.sv
      - hdl/axil_mem_result.sv
      - hdl/axil_mem_top.sv
  - target: test
    files:
      - tb/axil_mem_checker.sv
      - tb/tb_axil_mem.sv

// ==== hdl/axil_mem_decode.sv ====
// ========================================
// Holds one AW, one W and one AR at a time
// Issues at most one request per cycle
// ========================================
`timescale 1ns/1ps
`default_nettype none

`include "axil_mem_macros.svh"

module axil_mem_decode (
    input  logic                     aclk,
    input  logic                     aresetn,

    input  axil_mem_pkg::axil_addr_t awaddr,
    input  logic                     awvalid,
    output logic                     awready,

    input  axil_mem_pkg::axil_data_t wdata,
    input  axil_mem_pkg::axil_strb_t wstrb,
    input  logic                     wvalid,
    output logic                     wready,

    input  axil_mem_pkg::axil_addr_t araddr,
    input  logic                     arvalid,
    output logic                     arready,

    input  logic                     b_free,
    input  logic                     r_free,

    output axil_mem_pkg::mem_req_t   req,
    output logic                     req_valid
);

    import axil_mem_pkg::*;

    // Any word index at or past the RAM depth is an error
    function automatic logic addr_err(input axil_addr_t addr);
        return addr[`AXIL_ADDR_W-1:2] >= `AXIL_MEM_WORDS;
    endfunction

    logic       aw_full;
    word_idx_t  aw_idx;
    logic       aw_err;

    logic       w_full;
    axil_data_t w_data;
    axil_strb_t w_strb;

    logic       ar_full;
    word_idx_t  ar_idx;
    logic       ar_err;

    grant_e     last_grant;
    logic       write_elig;
    logic       read_elig;
    logic       grant_write;
    logic       grant_read;

    assign write_elig = aw_full && w_full && b_free;
    assign read_elig  = ar_full && r_free;

    // On a tie the type that lost last time goes first
    assign grant_write = write_elig && (!read_elig || last_grant == GRANT_READ);
    assign grant_read  = read_elig && !grant_write;

    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            aw_full    <= 1'b0;
            w_full     <= 1'b0;
            ar_full    <= 1'b0;
            awready    <= 1'b0;
            wready     <= 1'b0;
            arready    <= 1'b0;
            last_grant <= GRANT_READ;
        end else begin
            // Readies mirror the empty state of their holding registers
            if (awvalid && awready) begin
                aw_full <= 1'b1;
                awready <= 1'b0;
            end else if (grant_write) begin
                aw_full <= 1'b0;
                awready <= 1'b1;
            end else begin
                awready <= !aw_full;
            end

            if (wvalid && wready) begin
                w_full <= 1'b1;
                wready <= 1'b0;
            end else if (grant_write) begin
                w_full <= 1'b0;
                wready <= 1'b1;
            end else begin
                wready <= !w_full;
            end

            if (arvalid && arready) begin
                ar_full <= 1'b1;
                arready <= 1'b0;
            end else if (grant_read) begin
                ar_full <= 1'b0;
                arready <= 1'b1;
            end else begin
                arready <= !ar_full;
            end

            if (grant_write) last_grant <= GRANT_WRITE;
            else if (grant_read) last_grant <= GRANT_READ;
        end
    end

    // Payload captures only on the handshake
    always_ff @(posedge aclk) begin
        if (awvalid && awready) begin
            aw_idx <= awaddr[`AXIL_IDX_W+1:2];
            aw_err <= addr_err(awaddr);
        end
        if (wvalid && wready) begin
            w_data <= wdata;
            w_strb <= wstrb;
        end
        if (arvalid && arready) begin
            ar_idx <= araddr[`AXIL_IDX_W+1:2];
            ar_err <= addr_err(araddr);
        end
    end

    assign req_valid    = grant_write || grant_read;
    assign req.is_write = grant_write;
    assign req.err      = grant_write ? aw_err : ar_err;
    assign req.idx      = grant_write ? aw_idx : ar_idx;
    assign req.wdata    = w_data;
    assign req.wstrb    = w_strb;

    // A full holding register never offers ready
    a_ready_only_when_empty: assert property (@(posedge aclk) disable iff (!aresetn)
        !(awready && aw_full) && !(wready && w_full) && !(arready && ar_full));

endmodule

`default_nettype wire

// ==== hdl/axil_mem_execute.sv ====
// ========================================
// Byte-strobed RAM, contents undefined at power-up
// ========================================
`timescale 1ns/1ps
`default_nettype none

`include "axil_mem_macros.svh"

module axil_mem_execute (
    input  logic                   aclk,
    input  logic                   aresetn,

    input  axil_mem_pkg::mem_req_t req,
    input  logic                   req_valid,

    output axil_mem_pkg::mem_rsp_t rsp,
    output logic                   rsp_valid
);

    import axil_mem_pkg::*;

    axil_data_t mem [`AXIL_MEM_WORDS];

    // The index must address the whole RAM and nothing beyond it
    if (!IDX_W_MATCHES) begin : g_idx_check
        $error("AXIL_IDX_W does not match AXIL_MEM_WORDS");
    end

    // Writes land on the request edge, errored ones are dropped
    always_ff @(posedge aclk) begin
        if (req_valid && req.is_write && !req.err) begin
            for (int b = 0; b < `AXIL_STRB_W; b++) begin
                if (req.wstrb[b]) mem[req.idx][8*b +: 8] <= req.wdata[8*b +: 8];
            end
        end
    end

    always_ff @(posedge aclk) begin
        if (req_valid) begin
            rsp.is_write <= req.is_write;
            rsp.err      <= req.err;
            rsp.rdata    <= (req.is_write || req.err) ? '0 : mem[req.idx];
        end
    end

    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            rsp_valid <= 1'b0;
        end else begin
            rsp_valid <= req_valid;     // Fixed single cycle latency
        end
    end

    // The RAM must never see an unknown request type, error flag or index
    a_req_known: assert property (@(posedge aclk) disable iff (!aresetn)
        req_valid |-> !$isunknown({req.is_write, req.err, req.idx}));

endmodule

`default_nettype wire

// ==== hdl/axil_mem_macros.svh ====
// ========================================
// Widths and depth shared by RTL and testbench
// AXIL_IDX_W must be log2 of AXIL_MEM_WORDS
// ========================================
`ifndef AXIL_MEM_MACROS_SVH
`define AXIL_MEM_MACROS_SVH

// Byte address width of the AXI4-Lite bus
`define AXIL_ADDR_W 32

// Data width, only 32 is supported
`define AXIL_DATA_W 32

// One strobe bit per data byte
`define AXIL_STRB_W (`AXIL_DATA_W / 8)

// Number of 32-bit words in the RAM
`define AXIL_MEM_WORDS 256

// Word index width, 2**AXIL_IDX_W == AXIL_MEM_WORDS
`define AXIL_IDX_W 8

`endif

// ==== hdl/axil_mem_pkg.sv ====
// ========================================
// Types shared by the memory stages
// ========================================
`default_nettype none

`include "axil_mem_macros.svh"

package axil_mem_pkg;

    typedef logic [`AXIL_ADDR_W-1:0] axil_addr_t;
    typedef logic [`AXIL_DATA_W-1:0] axil_data_t;
    typedef logic [`AXIL_STRB_W-1:0] axil_strb_t;
    typedef logic [`AXIL_IDX_W-1:0]  word_idx_t;   // RAM word index, byte address bits dropped

    typedef logic [1:0] axil_resp_t;

    localparam axil_resp_t RESP_OKAY   = 2'b00;
    localparam axil_resp_t RESP_SLVERR = 2'b10;

    // Set when the index width covers the RAM exactly
    localparam bit IDX_W_MATCHES = ((1 << `AXIL_IDX_W) == `AXIL_MEM_WORDS);

    // Which request type the arbiter granted last
    typedef enum logic {
        GRANT_WRITE = 1'b0,
        GRANT_READ  = 1'b1
    } grant_e;

    // Decode to execute, one request per cycle
    typedef struct packed {
        logic       is_write;
        logic       err;        // Address beyond the RAM
        word_idx_t  idx;
        axil_data_t wdata;
        axil_strb_t wstrb;
    } mem_req_t;

    // Execute to result, one cycle after its request
    typedef struct packed {
        logic       is_write;
        logic       err;
        axil_data_t rdata;      // Zero for writes and errors
    } mem_rsp_t;

endpackage

`default_nettype wire

// ==== hdl/axil_mem_result.sv ====
// ========================================
// One B slot and one R slot, each reserved at issue
// ========================================
`timescale 1ns/1ps
`default_nettype none

module axil_mem_result (
    input  logic                       aclk,
    input  logic                       aresetn,

    input  logic                       req_valid,
    input  logic                       req_is_write,

    input  axil_mem_pkg::mem_rsp_t     rsp,
    input  logic                       rsp_valid,

    output logic                       bvalid,
    output axil_mem_pkg::axil_resp_t   bresp,
    input  logic                       bready,

    output logic                       rvalid,
    output axil_mem_pkg::axil_resp_t   rresp,
    output axil_mem_pkg::axil_data_t   rdata,
    input  logic                       rready,

    output logic                       b_free,
    output logic                       r_free
);

    import axil_mem_pkg::*;

    logic b_busy;   // A write is issued and its B handshake is still pending
    logic r_busy;

    // A slot can be reissued in the same cycle its handshake completes
    assign b_free = !b_busy || (bvalid && bready);
    assign r_free = !r_busy || (rvalid && rready);

    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            b_busy <= 1'b0;
            r_busy <= 1'b0;
        end else begin
            if (req_valid && req_is_write) b_busy <= 1'b1;
            else if (bvalid && bready) b_busy <= 1'b0;

            if (req_valid && !req_is_write) r_busy <= 1'b1;
            else if (rvalid && rready) r_busy <= 1'b0;
        end
    end

    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            bvalid <= 1'b0;
            rvalid <= 1'b0;
        end else begin
            if (rsp_valid && rsp.is_write) bvalid <= 1'b1;
            else if (bready) bvalid <= 1'b0;

            if (rsp_valid && !rsp.is_write) rvalid <= 1'b1;
            else if (rready) rvalid <= 1'b0;
        end
    end

    // The reservation guarantees the slot is empty when a response arrives
    always_ff @(posedge aclk) begin
        if (rsp_valid && rsp.is_write) begin
            bresp <= rsp.err ? RESP_SLVERR : RESP_OKAY;
        end
        if (rsp_valid && !rsp.is_write) begin
            rresp <= rsp.err ? RESP_SLVERR : RESP_OKAY;
            rdata <= rsp.rdata;
        end
    end

    a_b_stable: assert property (@(posedge aclk) disable iff (!aresetn)
        bvalid && !bready |=> bvalid && $stable(bresp));

    a_r_stable: assert property (@(posedge aclk) disable iff (!aresetn)
        rvalid && !rready |=> rvalid && $stable(rresp) && $stable(rdata));

endmodule

`default_nettype wire

// ==== hdl/axil_mem_top.sv ====
// ========================================
// AXI4-Lite memory slave, 32-bit, single beat
// PROT inputs are ignored, no preload
// ========================================
`timescale 1ns/1ps
`default_nettype none

module axil_mem_top (
    input  logic                     aclk,
    input  logic                     aresetn,

    input  axil_mem_pkg::axil_addr_t s_axil_awaddr,
    input  logic [2:0]               s_axil_awprot,
    input  logic                     s_axil_awvalid,
    output logic                     s_axil_awready,

    input  axil_mem_pkg::axil_data_t s_axil_wdata,
    input  axil_mem_pkg::axil_strb_t s_axil_wstrb,
    input  logic                     s_axil_wvalid,
    output logic                     s_axil_wready,

    output axil_mem_pkg::axil_resp_t s_axil_bresp,
    output logic                     s_axil_bvalid,
    input  logic                     s_axil_bready,

    input  axil_mem_pkg::axil_addr_t s_axil_araddr,
    input  logic [2:0]               s_axil_arprot,
    input  logic                     s_axil_arvalid,
    output logic                     s_axil_arready,

    output axil_mem_pkg::axil_data_t s_axil_rdata,
    output axil_mem_pkg::axil_resp_t s_axil_rresp,
    output logic                     s_axil_rvalid,
    input  logic                     s_axil_rready
);

    import axil_mem_pkg::*;

    mem_req_t req;
    logic     req_valid;
    mem_rsp_t rsp;
    logic     rsp_valid;
    logic     b_free;
    logic     r_free;

    axil_mem_decode axil_mem_decode_i (
        .aclk      (aclk),
        .aresetn   (aresetn),
        .awaddr    (s_axil_awaddr),
        .awvalid   (s_axil_awvalid),
        .awready   (s_axil_awready),
        .wdata     (s_axil_wdata),
        .wstrb     (s_axil_wstrb),
        .wvalid    (s_axil_wvalid),
        .wready    (s_axil_wready),
        .araddr    (s_axil_araddr),
        .arvalid   (s_axil_arvalid),
        .arready   (s_axil_arready),
        .b_free    (b_free),
        .r_free    (r_free),
        .req       (req),
        .req_valid (req_valid)
    );

    axil_mem_execute axil_mem_execute_i (
        .aclk      (aclk),
        .aresetn   (aresetn),
        .req       (req),
        .req_valid (req_valid),
        .rsp       (rsp),
        .rsp_valid (rsp_valid)
    );

    axil_mem_result axil_mem_result_i (
        .aclk         (aclk),
        .aresetn      (aresetn),
        .req_valid    (req_valid),
        .req_is_write (req.is_write),   // Reserves the B or R slot at issue
        .rsp          (rsp),
        .rsp_valid    (rsp_valid),
        .bvalid       (s_axil_bvalid),
        .bresp        (s_axil_bresp),
        .bready       (s_axil_bready),
        .rvalid       (s_axil_rvalid),
        .rresp        (s_axil_rresp),
        .rdata        (s_axil_rdata),
        .rready       (s_axil_rready),
        .b_free       (b_free),
        .r_free       (r_free)
    );

endmodule

`default_nettype wire

// ==== tb/axil_mem_checker.sv ====
// ========================================
// Model assumes no read overlaps a pending write to its word
// ========================================
`timescale 1ns/1ps
`default_nettype none

`include "axil_mem_macros.svh"

module axil_mem_checker (
    input  logic                     aclk,
    input  logic                     aresetn,
    input  axil_mem_pkg::axil_addr_t awaddr,
    input  logic                     awvalid,
    input  logic                     awready,
    input  axil_mem_pkg::axil_data_t wdata,
    input  axil_mem_pkg::axil_strb_t wstrb,
    input  logic                     wvalid,
    input  logic                     wready,
    input  axil_mem_pkg::axil_resp_t bresp,
    input  logic                     bvalid,
    input  logic                     bready,
    input  axil_mem_pkg::axil_addr_t araddr,
    input  logic                     arvalid,
    input  logic                     arready,
    input  axil_mem_pkg::axil_data_t rdata,
    input  axil_mem_pkg::axil_resp_t rresp,
    input  logic                     rvalid,
    input  logic                     rready,
    output int                       errors
);

    import axil_mem_pkg::*;

    axil_data_t model [`AXIL_MEM_WORDS];
    axil_addr_t aw_q [$];
    axil_data_t wdata_q [$];
    axil_strb_t wstrb_q [$];
    axil_data_t exp_rdata_q [$];     // Filled at AR handshake, in AR order
    axil_resp_t exp_rresp_q [$];
    logic       b_stalled;
    logic       r_stalled;
    axil_resp_t b_seen_resp;
    axil_resp_t r_seen_resp;
    axil_data_t r_seen_data;

    initial errors = 0;

    function automatic logic in_range(input axil_addr_t addr);
        return (addr >> 2) < `AXIL_MEM_WORDS;
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            errors++;
            $display("mismatch %s: got %08h expected %08h", name, got, exp);
        end
    endtask

    // Everything moves on the rising edge, so the falling edge sees settled values
    always @(negedge aclk) begin : watch
        axil_addr_t a;
        axil_data_t d;
        axil_strb_t s;
        if (!aresetn) begin
            b_stalled = 1'b0;
            r_stalled = 1'b0;
        end else begin
            if (b_stalled && !bvalid) begin
                errors++;
                $display("s_axil_bvalid dropped while s_axil_bready was low");
            end else if (b_stalled) begin
                check_value("s_axil_bresp", bresp, b_seen_resp);
            end
            if (r_stalled && !rvalid) begin
                errors++;
                $display("s_axil_rvalid dropped while s_axil_rready was low");
            end else if (r_stalled) begin
                check_value("s_axil_rresp", rresp, r_seen_resp);
                check_value("s_axil_rdata", rdata, r_seen_data);
            end
            b_stalled   = bvalid && !bready;
            b_seen_resp = bresp;
            r_stalled   = rvalid && !rready;
            r_seen_resp = rresp;
            r_seen_data = rdata;

            if (awvalid && awready) aw_q.push_back(awaddr);
            if (wvalid && wready) begin
                wdata_q.push_back(wdata);
                wstrb_q.push_back(wstrb);
            end
            if (bvalid && bready) begin
                if (aw_q.size() == 0 || wdata_q.size() == 0) begin
                    errors++;
                    $display("B response arrived with no write outstanding");
                end else begin
                    a = aw_q.pop_front();
                    d = wdata_q.pop_front();
                    s = wstrb_q.pop_front();
                    if (in_range(a)) begin
                        for (int b = 0; b < `AXIL_STRB_W; b++) begin
                            if (s[b]) model[a >> 2][8*b +: 8] = d[8*b +: 8];
                        end
                        check_value("s_axil_bresp", bresp, RESP_OKAY);
                    end else begin
                        check_value("s_axil_bresp", bresp, RESP_SLVERR);
                    end
                end
            end
            if (arvalid && arready) begin
                exp_rdata_q.push_back(in_range(araddr) ? model[araddr >> 2] : '0);
                exp_rresp_q.push_back(in_range(araddr) ? RESP_OKAY : RESP_SLVERR);
            end
            if (rvalid && rready) begin
                if (exp_rdata_q.size() == 0) begin
                    errors++;
                    $display("R response arrived with no read outstanding");
                end else begin
                    check_value("s_axil_rdata", rdata, exp_rdata_q.pop_front());
                    check_value("s_axil_rresp", rresp, exp_rresp_q.pop_front());
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== tb/tb_axil_mem.sv ====
// ========================================
// Fixed-seed traffic, one write and one read in flight at most
// ========================================
`timescale 1ns/1ps
`default_nettype none

`include "axil_mem_macros.svh"

module tb_axil_mem;

    import axil_mem_pkg::*;

    localparam int CLK_PERIOD = 8;
    localparam int N_FILL_RD  = 64;
    localparam int N_STRB     = 48;
    localparam int N_OOR      = 16;
    localparam int N_MIX      = 200;
    localparam int N_TXN      = 2 * `AXIL_MEM_WORDS + N_FILL_RD + 2 * (N_STRB + N_OOR + N_MIX);

    logic       aclk;
    logic       aresetn;
    axil_addr_t awaddr;
    logic       awvalid;
    logic       awready;
    axil_data_t wdata;
    axil_strb_t wstrb;
    logic       wvalid;
    logic       wready;
    axil_resp_t bresp;
    logic       bvalid;
    logic       bready;
    axil_addr_t araddr;
    logic       arvalid;
    logic       arready;
    axil_data_t rdata;
    axil_resp_t rresp;
    logic       rvalid;
    logic       rready;

    logic [31:0] rng;
    logic        stall_en;
    int          local_errors;
    int          checker_errors;
    int          tests_passed;
    int          tests_failed;
    bit          wr_busy [`AXIL_MEM_WORDS];    // Word has a write waiting for its B
    bit          rd_busy [`AXIL_MEM_WORDS];

    axil_mem_top axil_mem_top_i (
        .aclk           (aclk),
        .aresetn        (aresetn),
        .s_axil_awaddr  (awaddr),
        .s_axil_awprot  (3'b000),
        .s_axil_awvalid (awvalid),
        .s_axil_awready (awready),
        .s_axil_wdata   (wdata),
        .s_axil_wstrb   (wstrb),
        .s_axil_wvalid  (wvalid),
        .s_axil_wready  (wready),
        .s_axil_bresp   (bresp),
        .s_axil_bvalid  (bvalid),
        .s_axil_bready  (bready),
        .s_axil_araddr  (araddr),
        .s_axil_arprot  (3'b000),
        .s_axil_arvalid (arvalid),
        .s_axil_arready (arready),
        .s_axil_rdata   (rdata),
        .s_axil_rresp   (rresp),
        .s_axil_rvalid  (rvalid),
        .s_axil_rready  (rready)
    );

    axil_mem_checker checker_i (
        .errors  (checker_errors),
        .*
    );

    initial begin : clock_gen
        aclk = 1'b0;
        forever #(CLK_PERIOD / 2) aclk = ~aclk;
    end

    initial begin : watchdog
        #((N_TXN * 64 + 10) * CLK_PERIOD);
        $display("timeout: transactions did not complete");
        $display("Result: FAILED");
        $finish;
    end

    function automatic logic [31:0] next_rand();
        rng = rng ^ (rng << 13);
        rng = rng ^ (rng >> 17);
        rng = rng ^ (rng << 5);
        return rng;
    endfunction

    // Low two bits are random since the DUT ignores them
    function automatic axil_addr_t word_addr(input int idx);
        return (axil_addr_t'(idx) << 2) | (next_rand() & 32'h3);
    endfunction

    // Low spells of 0 to 3 cycles on bready and rready
    initial begin : ready_stalls
        int b_spell;
        int r_spell;
        b_spell = 0;
        r_spell = 0;
        forever begin
            @(posedge aclk);
            #1;
            bready = (b_spell == 0);
            rready = (r_spell == 0);
            if (b_spell > 0) b_spell--;
            else if (stall_en) b_spell = next_rand() % 4;
            if (r_spell > 0) r_spell--;
            else if (stall_en) r_spell = next_rand() % 4;
        end
    end

    // Every driver starts and ends 1 ns after a rising edge
    task automatic idle_cycles(input int n);
        repeat (n) begin
            @(posedge aclk);
            #1;
        end
    endtask

    task automatic send_aw(input axil_addr_t addr);
        awaddr  = addr;
        awvalid = 1'b1;
        @(negedge aclk);
        while (!awready) @(negedge aclk);
        @(posedge aclk);
        #1;
        awvalid = 1'b0;
    endtask

    task automatic send_w(input axil_data_t data, input axil_strb_t strb);
        wdata  = data;
        wstrb  = strb;
        wvalid = 1'b1;
        @(negedge aclk);
        while (!wready) @(negedge aclk);
        @(posedge aclk);
        #1;
        wvalid = 1'b0;
    endtask

    task automatic write_txn(input axil_addr_t addr, input axil_data_t data,
                             input axil_strb_t strb);
        int aw_gap;
        int w_gap;
        aw_gap = next_rand() % 3;        // Random gaps give AW first, W first or both
        w_gap  = next_rand() % 3;
        fork
            begin
                idle_cycles(aw_gap);
                send_aw(addr);
            end
            begin
                idle_cycles(w_gap);
                send_w(data, strb);
            end
        join
        @(negedge aclk);
        while (!(bvalid && bready)) @(negedge aclk);
        @(posedge aclk);
        #1;
    endtask

    task automatic read_txn(input axil_addr_t addr);
        araddr  = addr;
        arvalid = 1'b1;
        @(negedge aclk);
        while (!arready) @(negedge aclk);
        @(posedge aclk);
        #1;
        arvalid = 1'b0;
        @(negedge aclk);
        while (!(rvalid && rready)) @(negedge aclk);
        @(posedge aclk);
        #1;
    endtask

    task automatic mixed_writes(input int n);
        int idx;
        logic [31:0] r;
        for (int i = 0; i < n; i++) begin
            idle_cycles(next_rand() % 4);
            idx = next_rand() % `AXIL_MEM_WORDS;
            while (rd_busy[idx]) idx = next_rand() % `AXIL_MEM_WORDS;
            wr_busy[idx] = 1'b1;
            r = next_rand();
            write_txn(word_addr(idx), next_rand(), r[3:0]);
            wr_busy[idx] = 1'b0;
        end
    endtask

    task automatic mixed_reads(input int n);
        int idx;
        for (int i = 0; i < n; i++) begin
            idle_cycles(next_rand() % 4);
            idx = next_rand() % `AXIL_MEM_WORDS;
            while (wr_busy[idx]) idx = next_rand() % `AXIL_MEM_WORDS;
            rd_busy[idx] = 1'b1;
            read_txn(word_addr(idx));
            rd_busy[idx] = 1'b0;
        end
    endtask

    task automatic finish_test(input string name, input int errs_before);
        int errs;
        errs = local_errors + checker_errors - errs_before;
        if (errs == 0) begin
            tests_passed++;
            $display("test %s: ok", name);
        end else begin
            tests_failed++;
            $display("test %s: %0d errors", name, errs);
        end
    endtask

    initial begin : main
        int errs_before;
        int idx;
        logic [31:0] r;
        int touched [$];
        rng          = 32'd33579;
        stall_en     = 1'b0;
        local_errors = 0;
        tests_passed = 0;
        tests_failed = 0;
        aresetn      = 1'b0;
        awaddr       = '0;
        awvalid      = 1'b0;
        wdata        = '0;
        wstrb        = '0;
        wvalid       = 1'b0;
        bready       = 1'b0;
        araddr       = '0;
        arvalid      = 1'b0;
        rready       = 1'b0;

        errs_before = 0;
        repeat (2) @(posedge aclk);
        repeat (8) begin
            @(negedge aclk);
            if (awready || wready || arready || bvalid || rvalid) begin
                local_errors++;
                $display("reset: a ready or valid output was high during reset");
            end
        end
        @(posedge aclk);
        #1;
        aresetn = 1'b1;
        @(posedge aclk);
        @(negedge aclk);
        if (!(awready && wready && arready)) begin
            local_errors++;
            $display("reset: readies did not rise on the first edge after reset");
        end
        @(posedge aclk);
        #1;
        finish_test("reset", errs_before);

        errs_before = local_errors + checker_errors;
        for (int i = 0; i < `AXIL_MEM_WORDS; i++) write_txn(word_addr(i), next_rand(), 4'hf);
        for (int i = 0; i < N_FILL_RD; i++) read_txn(word_addr(next_rand() % `AXIL_MEM_WORDS));
        finish_test("fill_readback", errs_before);

        errs_before = local_errors + checker_errors;
        for (int i = 0; i < N_STRB; i++) begin
            idx = next_rand() % `AXIL_MEM_WORDS;
            r   = next_rand();
            touched.push_back(idx);
            write_txn(word_addr(idx), next_rand(), (r[3:0] == 4'hf) ? 4'h6 : r[3:0]);
        end
        foreach (touched[i]) read_txn(word_addr(touched[i]));
        finish_test("byte_strobes", errs_before);

        // Bit 10 set puts the word index at 256 or above
        errs_before = local_errors + checker_errors;
        for (int i = 0; i < N_OOR; i++) begin
            write_txn(next_rand() | 32'h400, next_rand(), 4'hf);
            read_txn(next_rand() | 32'h400);
        end
        for (int i = 0; i < `AXIL_MEM_WORDS; i++) read_txn(word_addr(i));
        finish_test("out_of_range", errs_before);

        errs_before = local_errors + checker_errors;
        stall_en = 1'b1;
        fork
            mixed_writes(N_MIX);
            mixed_reads(N_MIX);
        join
        stall_en = 1'b0;
        idle_cycles(8);     // Any duplicate response shows up in the checker here
        finish_test("concurrency", errs_before);

        $display("tests passed: %0d, tests failed: %0d, errors: %0d",
                 tests_passed, tests_failed, local_errors + checker_errors);
        if (tests_failed == 0 && local_errors + checker_errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== vlog.f ====
+incdir+hdl
hdl/axil_mem_pkg.sv
hdl/axil_mem_decode.sv
hdl/axil_mem_execute.sv
hdl/axil_mem_result.sv
hdl/axil_mem_top.sv
tb/axil_mem_checker.sv
tb/tb_axil_mem.sv
